// ==== Makefile ====
# Verilator flow for the PMP unit testbench
VERILATOR ?= verilator
TOP       ?= pmpUnitTb
RTL_TOP   ?= pmpUnit
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Testbench passed
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The run passes only if the log holds the pass line
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/pmpAdrDec.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmpAdrDec import pmpPkg::*; (
  input  logic [PA_BITS-1:0] physicalAddress,
  input  logic [7:0]         pmpCfg,
  input  logic [XLEN-1:0]    pmpAdr,
  input  logic               paGeAdrIn,
  input  logic               noLowerMatchIn,
  output logic               paGeAdrOut,
  output logic               noLowerMatchOut,
  output logic               match,
  output logic               active,
  output logic               lockedHit,
  output logic               execOk,
  output logic               writeOk,
  output logic               readOk
);

  logic [1:0]         adrMode;
  logic [PA_BITS-1:0] adrFull;
  logic [PA_BITS-1:0] ignoreMask;
  logic               paLtAdr;
  logic               torMatch;
  logic               naMatch;
  logic               firstMatch;

  assign adrMode = pmpCfg[CFG_A_LSB +: 2];

  ////////////////////
  // Top of range
  ////////////////////

  // pmpaddr holds address bits 33:2, so two zero bits are appended
  assign adrFull = {pmpAdr[PA_BITS-3:0], 2'b00};
  // Unsigned compare, the extra zero keeps it from going signed
  assign paLtAdr = {1'b0, physicalAddress} < {1'b0, adrFull};
  // The next entry uses this entry's address as its base
  assign paGeAdrOut = ~paLtAdr;
  assign torMatch = paGeAdrIn & paLtAdr;

  ////////////////////
  // NA4 and NAPOT
  ////////////////////

  // A one in the mask marks an address bit that is ignored
  // NAPOT grows the mask through every trailing one of pmpaddr
  always_comb begin
    ignoreMask[1:0] = 2'b11;
    // NA4 stops the mask at the byte offset
    ignoreMask[2] = (adrMode == MODE_NAPOT);
    for (int i = 3; i < PA_BITS; i++) begin
      ignoreMask[i] = ignoreMask[i-1] & pmpAdr[i-3];
    end
  end

  assign naMatch = &((physicalAddress ~^ adrFull) | ignoreMask);

  always_comb begin
    case (adrMode)
      MODE_TOR:   match = torMatch;
      MODE_NA4:   match = naMatch;
      MODE_NAPOT: match = naMatch;
      default:    match = 1'b0;
    endcase
  end

  // Only the lowest-numbered matching entry takes part in the decision
  assign firstMatch = noLowerMatchIn & match;
  assign noLowerMatchOut = noLowerMatchIn & ~match;

  assign lockedHit = pmpCfg[CFG_L_BIT] & firstMatch;
  assign execOk = pmpCfg[CFG_X_BIT] & firstMatch;
  assign writeOk = pmpCfg[CFG_W_BIT] & firstMatch;
  assign readOk = pmpCfg[CFG_R_BIT] & firstMatch;
  assign active = (adrMode != MODE_OFF);

endmodule

`default_nettype wire

// ==== rtl/pmpChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmpChecker import pmpPkg::*; (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             reqValid,
  input  logic [PA_BITS-1:0]               reqAdr,
  input  logic [1:0]                       reqType,
  input  logic                             reqMachine,
  input  logic [PMP_ENTRIES-1:0][7:0]      pmpCfg,
  input  logic [PMP_ENTRIES-1:0][XLEN-1:0] pmpAdr,
  output logic                             rspValid,
  output logic                             rspFault
);

  // Chain between neighboring decoders, bit 0 feeds entry 0
  logic [PMP_ENTRIES-1:0] geChain;
  logic [PMP_ENTRIES:0]   noLowerChain;
  logic [PMP_ENTRIES-1:0] activeVec;
  logic [PMP_ENTRIES-1:0] lockedVec;
  logic [PMP_ENTRIES-1:0] execVec;
  logic [PMP_ENTRIES-1:0] writeVec;
  logic [PMP_ENTRIES-1:0] readVec;
  logic                   anyMatch;
  logic                   permOk;
  logic                   faultNext;

  // Region of entry 0 starts at address zero
  assign geChain[0] = 1'b1;
  assign noLowerChain[0] = 1'b1;

  ////////////////////
  // Decoder chain
  ////////////////////

  for (genvar e = 0; e < PMP_ENTRIES; e++) begin : gDec
    logic geOut;

    pmpAdrDec dec (
      .physicalAddress (reqAdr),
      .pmpCfg          (pmpCfg[e]),
      .pmpAdr          (pmpAdr[e]),
      .paGeAdrIn       (geChain[e]),
      .noLowerMatchIn  (noLowerChain[e]),
      .paGeAdrOut      (geOut),
      .noLowerMatchOut (noLowerChain[e+1]),
      .match           (),
      .active          (activeVec[e]),
      .lockedHit       (lockedVec[e]),
      .execOk          (execVec[e]),
      .writeOk         (writeVec[e]),
      .readOk          (readVec[e])
    );

    // The last entry has no neighbor above, its compare result stops here
    if (e < PMP_ENTRIES - 1) begin : gFwd
      assign geChain[e+1] = geOut;
    end
  end

  ////////////////////
  // Fault decision
  ////////////////////

  // At most one entry is the first match, so OR gives its permissions
  assign anyMatch = ~noLowerChain[PMP_ENTRIES];

  always_comb begin
    case (reqType)
      ACC_READ:  permOk = |readVec;
      ACC_WRITE: permOk = |writeVec;
      ACC_EXEC:  permOk = |execVec;
      // Reserved type has no permission bit
      default:   permOk = 1'b0;
    endcase
  end

  // Machine mode is only held to the rules of a locked entry
  // With no match, user mode faults once any entry is active
  assign faultNext = anyMatch ? (~permOk & (~reqMachine | (|lockedVec)))
                              : (~reqMachine & (|activeVec));

  always_ff @(posedge clk) begin
    if (reset) begin
      rspValid <= 1'b0;
      rspFault <= 1'b0;
    end else begin
      rspValid <= reqValid;
      rspFault <= reqValid & faultNext;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/pmpCsrFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmpCsrFile import pmpPkg::*; (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             csrWe,
  input  logic [3:0]                       csrSel,
  input  logic [XLEN-1:0]                  csrWData,
  output logic [XLEN-1:0]                  csrRData,
  output logic [PMP_ENTRIES-1:0][7:0]      pmpCfg,
  output logic [PMP_ENTRIES-1:0][XLEN-1:0] pmpAdr
);

  pmpCfgWordT                     wrWord;
  pmpCfgWordT                     rdWord;
  logic [PMP_ENTRIES-1:0][7:0]    cfgNext;
  logic [PMP_ENTRIES-1:0]         cfgWrEn;
  logic [PMP_ENTRIES-1:0]         adrWrEn;
  logic [PMP_ENTRIES-1:0]         adrLocked;

  // Incoming data split into its four cfg bytes
  assign wrWord.word = csrWData;

  ////////////////////
  // Write enables
  ////////////////////

  for (genvar e = 0; e < PMP_ENTRIES; e++) begin : gEntry
    // Entries 0 to 3 sit in pmpcfg0, entries 4 to 7 in pmpcfg1
    localparam logic [3:0] cfgSel = (e < CFG_BYTES) ? SEL_CFG0 : SEL_CFG1;

    assign cfgNext[e] = wrWord.cfgByte[e % CFG_BYTES];

    // A locked cfg byte keeps its value until reset
    assign cfgWrEn[e] = csrWe & (csrSel == cfgSel) & ~pmpCfg[e][CFG_L_BIT];

    // The pmpaddr below a locked TOR entry is that entry's base, so it freezes too
    if (e < PMP_ENTRIES - 1) begin : gTorLock
      assign adrLocked[e] = pmpCfg[e][CFG_L_BIT] |
                            (pmpCfg[e+1][CFG_L_BIT] &
                             (pmpCfg[e+1][CFG_A_LSB +: 2] == MODE_TOR));
    end else begin : gLastLock
      assign adrLocked[e] = pmpCfg[e][CFG_L_BIT];
    end

    assign adrWrEn[e] = csrWe & (csrSel == SEL_ADR_BASE + 4'(e)) & ~adrLocked[e];
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      pmpCfg <= '0;
      pmpAdr <= '0;
    end else begin
      for (int e = 0; e < PMP_ENTRIES; e++) begin
        if (cfgWrEn[e]) begin
          pmpCfg[e] <= cfgNext[e];
        end
        if (adrWrEn[e]) begin
          pmpAdr[e] <= csrWData;
        end
      end
    end
  end

  ////////////////////
  // Read-back
  ////////////////////

  // Selectors 2 to 7 are unused and read as zero
  always_comb begin
    rdWord.word = '0;
    if (csrSel == SEL_CFG0) begin
      rdWord.cfgByte = pmpCfg[CFG_BYTES-1:0];
    end else if (csrSel == SEL_CFG1) begin
      rdWord.cfgByte = pmpCfg[PMP_ENTRIES-1:CFG_BYTES];
    end else if (csrSel >= SEL_ADR_BASE) begin
      rdWord.word = pmpAdr[csrSel[2:0]];
    end
  end

  assign csrRData = rdWord.word;

endmodule

`default_nettype wire

// ==== rtl/pmpPkg.sv ====
`default_nettype none

package pmpPkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Width of one CSR word on this RV32 core
  localparam int XLEN = 32;
  // Sv32 physical address width
  localparam int PA_BITS = 34;
  localparam int PMP_ENTRIES = 8;
  // Each pmpcfg word carries four entry configurations
  localparam int CFG_BYTES = 4;

  ////////////////////
  // Cfg byte fields
  ////////////////////

  // Address-matching modes held in the A field
  localparam logic [1:0] MODE_OFF = 2'd0;
  localparam logic [1:0] MODE_TOR = 2'd1;
  localparam logic [1:0] MODE_NA4 = 2'd2;
  localparam logic [1:0] MODE_NAPOT = 2'd3;

  localparam int CFG_R_BIT = 0;
  localparam int CFG_W_BIT = 1;
  localparam int CFG_X_BIT = 2;
  // The A field occupies this bit and the one above it
  localparam int CFG_A_LSB = 3;
  localparam int CFG_L_BIT = 7;

  ////////////////////
  // Bus encodings
  ////////////////////

  // CSR selectors, pmpaddr i lives at SEL_ADR_BASE + i
  localparam logic [3:0] SEL_CFG0 = 4'd0;
  localparam logic [3:0] SEL_CFG1 = 4'd1;
  localparam logic [3:0] SEL_ADR_BASE = 4'd8;

  // Access types of a request
  localparam logic [1:0] ACC_READ = 2'd0;
  localparam logic [1:0] ACC_WRITE = 2'd1;
  localparam logic [1:0] ACC_EXEC = 2'd2;

  // A pmpcfg word seen either as one raw word or as four cfg bytes
  // Byte k of pmpcfg w configures entry 4*w+k
  typedef union packed {
    logic [XLEN-1:0] word;
    logic [CFG_BYTES-1:0][7:0] cfgByte;
  } pmpCfgWordT;

endpackage

`default_nettype wire

// ==== rtl/pmpUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmpUnit import pmpPkg::*; (
  input  logic               clk,
  input  logic               reset,
  // CSR access
  input  logic               csrWe,
  input  logic [3:0]         csrSel,
  input  logic [XLEN-1:0]    csrWData,
  output logic [XLEN-1:0]    csrRData,
  // Check request and its response one cycle later
  input  logic               reqValid,
  input  logic [PA_BITS-1:0] reqAdr,
  input  logic [1:0]         reqType,
  input  logic               reqMachine,
  output logic               rspValid,
  output logic               rspFault
);

  logic [PMP_ENTRIES-1:0][7:0]      pmpCfg;
  logic [PMP_ENTRIES-1:0][XLEN-1:0] pmpAdr;

  pmpCsrFile csr0 (
    .clk      (clk),
    .reset    (reset),
    .csrWe    (csrWe),
    .csrSel   (csrSel),
    .csrWData (csrWData),
    .csrRData (csrRData),
    .pmpCfg   (pmpCfg),
    .pmpAdr   (pmpAdr)
  );

  // Checks use the registered CSR state, so same-cycle writes are not seen
  pmpChecker chk0 (
    .clk        (clk),
    .reset      (reset),
    .reqValid   (reqValid),
    .reqAdr     (reqAdr),
    .reqType    (reqType),
    .reqMachine (reqMachine),
    .pmpCfg     (pmpCfg),
    .pmpAdr     (pmpAdr),
    .rspValid   (rspValid),
    .rspFault   (rspFault)
  );

endmodule

`default_nettype wire

// ==== test/pmpMonitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmpMonitor import pmpPkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               csrWe,
  input  logic [3:0]         csrSel,
  input  logic [XLEN-1:0]    csrWData,
  input  logic [XLEN-1:0]    csrRData,
  input  logic               readCheck,
  input  logic               reqValid,
  input  logic [PA_BITS-1:0] reqAdr,
  input  logic [1:0]         reqType,
  input  logic               reqMachine,
  input  logic               rspValid,
  input  logic               rspFault,
  output int                 errCount
);

  // Shadow copy of the CSR state, built from the observed writes
  logic [7:0]      shadowCfg [PMP_ENTRIES];
  logic [XLEN-1:0] shadowAdr [PMP_ENTRIES];
  logic            pendValid;
  logic            pendFault;

  //////////////////////
  // Reference model
  //////////////////////

  // Walks the entries from 0 upward, the first one that covers the address decides
  function automatic logic expectedFault(logic [PA_BITS-1:0] a, logic [1:0] t, logic m);
    logic [63:0] addr;
    logic [63:0] lo;
    logic [63:0] hi;
    logic [63:0] size;
    logic [1:0]  mode;
    logic        hit;
    logic        found;
    logic        perm;
    logic        fault;
    logic        anyActive;
    int          ones;
    addr = {30'd0, a};
    found = 1'b0;
    fault = 1'b0;
    anyActive = 1'b0;
    for (int e = 0; e < PMP_ENTRIES; e++) begin
      mode = shadowCfg[e][4:3];
      hi = {30'd0, shadowAdr[e], 2'd0};
      hit = 1'b0;
      if (mode != MODE_OFF) begin
        anyActive = 1'b1;
      end
      if (mode == MODE_TOR) begin
        lo = (e == 0) ? 64'd0 : {30'd0, shadowAdr[e-1], 2'd0};
        hit = (addr >= lo) && (addr < hi);
      end else if (mode == MODE_NA4) begin
        hit = (addr >> 2) == {32'd0, shadowAdr[e]};
      end else if (mode == MODE_NAPOT) begin
        // Region size doubles with each trailing one, starting at 8 bytes
        ones = 0;
        while (ones < 32 && shadowAdr[e][ones]) begin
          ones++;
        end
        size = 64'd8 << ones;
        lo = hi & ~(size - 64'd1);
        hit = (addr >= lo) && (addr < lo + size);
      end
      if (hit && !found) begin
        found = 1'b1;
        case (t)
          ACC_READ:  perm = shadowCfg[e][0];
          ACC_WRITE: perm = shadowCfg[e][1];
          ACC_EXEC:  perm = shadowCfg[e][2];
          default:   perm = 1'b0;
        endcase
        fault = !perm && (!m || shadowCfg[e][7]);
      end
    end
    if (!found) begin
      fault = !m && anyActive;
    end
    return fault;
  endfunction

  function automatic logic [XLEN-1:0] expectedRead(logic [3:0] sel);
    pmpCfgWordT w;
    w.word = '0;
    if (sel < 4'd2) begin
      for (int k = 0; k < CFG_BYTES; k++) begin
        w.cfgByte[k] = shadowCfg[4 * int'(sel) + k];
      end
    end else if (sel >= 4'd8) begin
      w.word = shadowAdr[int'(sel) - 8];
    end
    return w.word;
  endfunction

  // Lock rules come from the state before the write
  task automatic applyWrite(logic [3:0] sel, logic [XLEN-1:0] data);
    pmpCfgWordT w;
    int         i;
    logic       locked;
    w.word = data;
    if (sel < 4'd2) begin
      for (int k = 0; k < CFG_BYTES; k++) begin
        i = 4 * int'(sel) + k;
        if (!shadowCfg[i][7]) begin
          shadowCfg[i] = w.cfgByte[k];
        end
      end
    end else if (sel >= 4'd8) begin
      i = int'(sel) - 8;
      locked = shadowCfg[i][7];
      if (i < PMP_ENTRIES - 1) begin
        locked = locked || (shadowCfg[i+1][7] && shadowCfg[i+1][4:3] == MODE_TOR);
      end
      if (!locked) begin
        shadowAdr[i] = data;
      end
    end
  endtask

  //////////////////////
  // Comparison
  //////////////////////

  initial begin
    errCount = 0;
    pendValid = 1'b0;
    pendFault = 1'b0;
  end

  always @(posedge clk) begin
    if (reset) begin
      for (int e = 0; e < PMP_ENTRIES; e++) begin
        shadowCfg[e] = '0;
        shadowAdr[e] = '0;
      end
      pendValid = 1'b0;
    end else begin
      // Outputs still hold what the previous edge registered
      if (pendValid && !rspValid) begin
        $display("Response missing one cycle after a request at time %0t", $time);
        errCount++;
      end else if (pendValid && rspFault !== pendFault) begin
        $display("FAILED at %0t: rspFault is %b, expected %b", $time, rspFault, pendFault);
        errCount++;
      end else if (!pendValid && rspValid) begin
        $display("FAILED at %0t: rspValid without a request", $time);
        errCount++;
      end
      if (readCheck && csrRData !== expectedRead(csrSel)) begin
        $display("FAILED at %0t: csr %0d reads %h, expected %h",
                 $time, csrSel, csrRData, expectedRead(csrSel));
        errCount++;
      end
      // A request in this cycle sees the registers from before any write here
      pendValid = reqValid;
      if (reqValid) begin
        pendFault = expectedFault(reqAdr, reqType, reqMachine);
      end
      if (csrWe) begin
        applyWrite(csrSel, csrWData);
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/pmpUnitAssert.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmpUnitAssert import pmpPkg::*; (
  input logic                        clk,
  input logic                        reset,
  input logic                        reqValid,
  input logic                        rspValid,
  input logic                        rspFault,
  input logic [PMP_ENTRIES-1:0][7:0] pmpCfg
);

  // Response stage comes out of reset idle
  afterReset: assert property (@(posedge clk) $past(reset) |-> !rspValid)
    else $error("rspValid high right after reset");

  // Exactly one response per request, one cycle later
  oneCycle: assert property (@(posedge clk) disable iff (reset)
    !$past(reset) |-> rspValid == $past(reqValid))
    else $error("rspValid does not follow reqValid");

  faultValid: assert property (@(posedge clk) rspFault |-> rspValid)
    else $error("rspFault without rspValid");

  for (genvar e = 0; e < PMP_ENTRIES; e++) begin : gLock
    lockHold: assert property (@(posedge clk) disable iff (reset)
      (!$past(reset) && $past(pmpCfg[e][CFG_L_BIT])) |-> pmpCfg[e] == $past(pmpCfg[e]))
      else $error("Locked cfg byte %0d changed", e);
  end

endmodule

// The checker sees both the response stage and the cfg bytes
bind pmpChecker pmpUnitAssert assert0 (
  .clk      (clk),
  .reset    (reset),
  .reqValid (reqValid),
  .rspValid (rspValid),
  .rspFault (rspFault),
  .pmpCfg   (pmpCfg)
);

`default_nettype wire

// ==== test/pmpUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmpUnitTb import pmpPkg::*; ();

  logic               clk;
  logic               reset;
  logic               csrWe;
  logic [3:0]         csrSel;
  logic [XLEN-1:0]    csrWData;
  logic [XLEN-1:0]    csrRData;
  logic               reqValid;
  logic [PA_BITS-1:0] reqAdr;
  logic [1:0]         reqType;
  logic               reqMachine;
  logic               rspValid;
  logic               rspFault;
  logic               readCheck;
  int                 errCount;
  int                 passCount;
  int                 failCount;
  int                 errBefore;
  logic [31:0]        lfsr;
  logic [63:0]        rnd;
  logic [63:0]        rnd2;
  logic [XLEN-1:0]    adrVal;
  logic [31:0]        cfgWord;

  pmpUnit dut0 (
    .clk        (clk),
    .reset      (reset),
    .csrWe      (csrWe),
    .csrSel     (csrSel),
    .csrWData   (csrWData),
    .csrRData   (csrRData),
    .reqValid   (reqValid),
    .reqAdr     (reqAdr),
    .reqType    (reqType),
    .reqMachine (reqMachine),
    .rspValid   (rspValid),
    .rspFault   (rspFault)
  );

  pmpMonitor mon0 (
    .clk        (clk),
    .reset      (reset),
    .csrWe      (csrWe),
    .csrSel     (csrSel),
    .csrWData   (csrWData),
    .csrRData   (csrRData),
    .readCheck  (readCheck),
    .reqValid   (reqValid),
    .reqAdr     (reqAdr),
    .reqType    (reqType),
    .reqMachine (reqMachine),
    .rspValid   (rspValid),
    .rspFault   (rspFault),
    .errCount   (errCount)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////
  // Helpers
  //////////////////////

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsrStep(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic drawBits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrStep(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  task automatic stopOnTimeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Testbench failed");
    $finish;
  endtask

  task automatic writeCsr(input logic [3:0] sel, input logic [XLEN-1:0] data);
    @(negedge clk);
    csrWe = 1'b1;
    csrSel = sel;
    csrWData = data;
    @(negedge clk);
    csrWe = 1'b0;
  endtask

  task automatic checkRead(input logic [3:0] sel);
    @(negedge clk);
    csrSel = sel;
    readCheck = 1'b1;
    @(negedge clk);
    readCheck = 1'b0;
  endtask

  task automatic sendRequest(input logic [PA_BITS-1:0] adr, input logic [1:0] t,
                             input logic m);
    int waited;
    @(negedge clk);
    reqValid = 1'b1;
    reqAdr = adr;
    reqType = t;
    reqMachine = m;
    @(negedge clk);
    reqValid = 1'b0;
    waited = 0;
    while (!rspValid) begin
      if (waited >= 8) begin
        stopOnTimeout("a response");
      end
      @(negedge clk);
      waited++;
    end
  endtask

  // Address is drawn from the lowest adrBits bits of the space
  task automatic randomRequest(input int adrBits);
    drawBits(adrBits, rnd);
    drawBits(3, rnd2);
    sendRequest(rnd[PA_BITS-1:0], rnd2[1:0], rnd2[2]);
  endtask

  // Each address tried with every type in both privilege modes
  task automatic sweepAddress(input logic [PA_BITS-1:0] adr);
    for (int t = 0; t < 3; t++) begin
      sendRequest(adr, 2'(t), 1'b0);
      sendRequest(adr, 2'(t), 1'b1);
    end
  endtask

  task automatic closeTest(input string name);
    int errs;
    errs = errCount - errBefore;
    $display("%s: %0d errors", name, errs);
    if (errs == 0) begin
      passCount++;
    end else begin
      failCount++;
    end
    errBefore = errCount;
  endtask

  //////////////////////
  // Tests
  //////////////////////

  initial begin
    reset = 1'b1;
    csrWe = 1'b0;
    csrSel = '0;
    csrWData = '0;
    reqValid = 1'b0;
    reqAdr = '0;
    reqType = '0;
    reqMachine = 1'b0;
    readCheck = 1'b0;
    lfsr = 32'd36;
    passCount = 0;
    failCount = 0;
    errBefore = 0;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    // Nothing is active after reset
    for (int s = 0; s < 16; s++) begin
      checkRead(4'(s));
    end
    repeat (20) randomRequest(14);
    closeTest("reset state");

    // Entry 1 is TOR over 0x1000..0x1fff read only and entry 2 is NA4 at 0x3000 write and exec
    writeCsr(SEL_ADR_BASE, 32'h0000_0400);
    writeCsr(SEL_ADR_BASE + 4'd1, 32'h0000_0800);
    writeCsr(SEL_ADR_BASE + 4'd2, 32'h0000_0c00);
    writeCsr(SEL_CFG0, 32'h0016_0900);
    checkRead(SEL_CFG0);
    checkRead(SEL_ADR_BASE + 4'd1);
    sweepAddress(34'h0ffc);
    sweepAddress(34'h1000);
    sweepAddress(34'h1ffc);
    sweepAddress(34'h2000);
    sweepAddress(34'h2ffc);
    sweepAddress(34'h3000);
    sweepAddress(34'h3004);
    closeTest("tor and na4");

    // Entries 4 to 7 hold NAPOT regions that overlap inside the lowest 2 KB
    cfgWord = '0;
    for (int e = 0; e < 4; e++) begin
      drawBits(9, rnd);
      drawBits(3, rnd2);
      adrVal = {23'd0, rnd[8:0]};
      adrVal = (adrVal & ~((32'd2 << rnd2[2:0]) - 32'd1)) | ((32'd1 << rnd2[2:0]) - 32'd1);
      writeCsr(SEL_ADR_BASE + 4'd4 + 4'(e), adrVal);
      drawBits(3, rnd2);
      cfgWord[8*e +: 8] = {5'b00011, rnd2[2:0]};
    end
    writeCsr(SEL_CFG1, cfgWord);
    checkRead(SEL_CFG1);
    repeat (40) randomRequest(11);
    closeTest("napot and priority");

    // Entry 3 is a locked read-only TOR and its base pmpaddr2 freezes with it
    writeCsr(SEL_ADR_BASE + 4'd3, 32'h0000_1400);
    writeCsr(SEL_CFG0, 32'h8916_0900);
    writeCsr(SEL_CFG0, 32'h0000_0000);
    writeCsr(SEL_ADR_BASE + 4'd3, 32'h0000_0123);
    writeCsr(SEL_ADR_BASE + 4'd2, 32'h0000_0456);
    writeCsr(SEL_ADR_BASE + 4'd1, 32'h0000_0789);
    for (int s = 0; s < 2; s++) begin
      checkRead(4'(s));
    end
    for (int s = 8; s < 12; s++) begin
      checkRead(4'(s));
    end
    sweepAddress(34'h3000);
    sweepAddress(34'h4ffc);
    sweepAddress(34'h5000);
    closeTest("lock");

    // A request every cycle with CSR writes mixed in
    for (int c = 0; c < 60; c++) begin
      @(negedge clk);
      drawBits(14, rnd);
      drawBits(3, rnd2);
      reqValid = 1'b1;
      reqAdr = {20'd0, rnd[13:0]};
      reqType = rnd2[1:0];
      reqMachine = rnd2[2];
      drawBits(2, rnd2);
      csrWe = (rnd2[1:0] == 2'b00);
      drawBits(4, rnd);
      csrSel = rnd[3:0];
      drawBits(32, rnd);
      csrWData = rnd[31:0];
      readCheck = 1'b1;
    end
    @(negedge clk);
    reqValid = 1'b0;
    csrWe = 1'b0;
    readCheck = 1'b0;
    for (int waited = 0; rspValid; waited++) begin
      if (waited >= 8) begin
        stopOnTimeout("the response stream to drain");
      end
      @(negedge clk);
    end
    closeTest("back to back");

    $display("Tests passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0 && errCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Whole-run limit in case a loop above never ends
  initial begin
    for (int cycles = 0; cycles < 20000; cycles++) begin
      @(posedge clk);
    end
    stopOnTimeout("the end of the run");
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/pmpPkg.sv
rtl/pmpAdrDec.sv
rtl/pmpCsrFile.sv
rtl/pmpChecker.sv
rtl/pmpUnit.sv
test/pmpMonitor.sv
test/pmpUnitAssert.sv
test/pmpUnitTb.sv
